/* deparser_pkg.sv */
package deparser_pkg;

	localparam int DATA_W = 128;
	localparam int KEEP_W = DATA_W / 8;
	localparam int HDR_BEATS = 2;
	localparam int HDR_BYTES = HDR_BEATS * KEEP_W;

	localparam int N_SLOTS = 4;
	localparam int N_CONT = 4;
	localparam int ACT_W = 16;
	localparam int ROW_W = ACT_W * N_SLOTS;
	localparam int TBL_DEPTH = 16;
	localparam int TBL_AW = $clog2(TBL_DEPTH);

	typedef enum logic [1:0] {
		CONT_NONE = 2'd0,
		CONT_2B   = 2'd1,
		CONT_4B   = 2'd2,
		CONT_6B   = 2'd3
	} cont_kind_e;

	// lsb first: valid, idx, kind, offset
	typedef struct packed {
		logic [2:0] rsvd;
		logic [6:0] offset;
		cont_kind_e kind;
		logic [2:0] idx;
		logic valid;
	} action_t;

	typedef struct packed {
		logic [N_CONT-1:0][47:0] c6;
		logic [N_CONT-1:0][31:0] c4;
		logic [N_CONT-1:0][15:0] c2;
		logic [11:0] vlan_id;
	} phv_t;

	// first beat of a table load
	localparam logic [2:0] DEPARSER_ID = 3'd5;
	localparam logic [15:0] CTRL_FLAG = 16'hf2f1;
	localparam int CTRL_IDX_LSB = 64;
	localparam int CTRL_FLAG_LSB = 80;
	localparam int CTRL_ID_LSB = 96;

	// row select is vlan_id[7:4]
	localparam int VLAN_IDX_LSB = 4;

endpackage

/* action_table.sv */
`timescale 1ns/100ps

module action_table #(
	parameter int DATA_W = deparser_pkg::DATA_W,
	parameter int ROW_W = deparser_pkg::ROW_W,
	parameter int TBL_DEPTH = deparser_pkg::TBL_DEPTH
) (
	input logic clk,
	input logic aresetn,
	input logic [DATA_W-1:0] ctrl_data,
	input logic ctrl_valid,
	input logic ctrl_last,
	input logic [$clog2(TBL_DEPTH)-1:0] rd_addr,
	output logic [ROW_W-1:0] row
);
	import deparser_pkg::*;

	localparam int AW = $clog2(TBL_DEPTH);

	typedef enum logic {
		LD_IDLE,
		LD_WRITE
	} ld_state_e;

	ld_state_e ld_state;
	logic [AW-1:0] wr_idx;
	logic wr_en;
	logic hdr_match;
	logic [ROW_W-1:0] tbl [TBL_DEPTH];

	// a header beat that is also last carries no rows
	assign hdr_match = ctrl_valid && !ctrl_last &&
		(ctrl_data[CTRL_ID_LSB +: $bits(DEPARSER_ID)] == DEPARSER_ID) &&
		(ctrl_data[CTRL_FLAG_LSB +: $bits(CTRL_FLAG)] == CTRL_FLAG);

	assign wr_en = (ld_state == LD_WRITE) && ctrl_valid;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			ld_state <= LD_IDLE;
			wr_idx <= '0;
		end else begin
			case (ld_state)
				LD_IDLE: begin
					if (hdr_match) begin
						wr_idx <= ctrl_data[CTRL_IDX_LSB +: AW];
						ld_state <= LD_WRITE;
					end
				end
				LD_WRITE: begin
					if (ctrl_valid) begin
						// index wraps around the table
						wr_idx <= wr_idx + 1'b1;
						if (ctrl_last) begin
							ld_state <= LD_IDLE;
						end
					end
				end
				default: ld_state <= LD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < TBL_DEPTH; i++) begin
				tbl[i] <= '0;
			end
			row <= '0;
		end else begin
			if (wr_en) begin
				tbl[wr_idx] <= ctrl_data[ROW_W-1:0];
			end
			row <= tbl[rd_addr];
		end
	end

	// an idle loader leaves the table alone, seen through the read port
	no_idle_write: assert property (@(posedge clk) disable iff (!aresetn)
		$past(ld_state == LD_IDLE, 2) && ($past(rd_addr) == $past(rd_addr, 2))
		|-> $stable(row));

endmodule

/* sub_deparser.sv */
`timescale 1ns/100ps

module sub_deparser (
	input logic clk,
	input logic aresetn,
	input deparser_pkg::action_t act,
	input logic act_start,
	input deparser_pkg::phv_t phv,
	output logic [47:0] cont_val,
	output logic [2:0] cont_len
);
	import deparser_pkg::*;

	localparam int IDX_W = $clog2(N_CONT);

	logic [IDX_W-1:0] cidx;
	logic [47:0] sel_val;
	logic [2:0] sel_len;

	assign cidx = act.idx[IDX_W-1:0];

	// container pick, right-aligned
	always_comb begin
		sel_val = '0;
		sel_len = 3'd0;
		if (act.valid) begin
			case (act.kind)
				CONT_2B: begin
					sel_val = {32'd0, phv.c2[cidx]};
					sel_len = 3'd2;
				end
				CONT_4B: begin
					sel_val = {16'd0, phv.c4[cidx]};
					sel_len = 3'd4;
				end
				CONT_6B: begin
					sel_val = phv.c6[cidx];
					sel_len = 3'd6;
				end
				default: begin
					sel_val = '0;
					sel_len = 3'd0;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			cont_len <= 3'd0;
		end else if (act_start) begin
			cont_len <= sel_len;
		end
	end

	always_ff @(posedge clk) begin
		if (act_start) begin
			cont_val <= sel_val;
		end
	end

	// table rows must only name existing containers
	idx_in_range: assert property (@(posedge clk) disable iff (!aresetn)
		act_start && act.valid |-> act.idx < N_CONT);

endmodule

/* deparse_ctrl.sv */
`timescale 1ns/100ps

module deparse_ctrl #(
	parameter int DATA_W = deparser_pkg::DATA_W,
	parameter int N_SLOTS = deparser_pkg::N_SLOTS
) (
	input logic clk,
	input logic aresetn,
	input logic [DATA_W-1:0] pkt_data,
	input logic [DATA_W/8-1:0] pkt_keep,
	input logic pkt_last,
	input logic pkt_empty,
	output logic pkt_pop,
	input logic phv_empty,
	output logic phv_pop,
	input logic [deparser_pkg::ACT_W*N_SLOTS-1:0] row,
	output deparser_pkg::action_t [N_SLOTS-1:0] acts,
	output logic act_start,
	input logic [N_SLOTS-1:0][47:0] cont_val,
	input logic [N_SLOTS-1:0][2:0] cont_len,
	output logic [DATA_W-1:0] out_data,
	output logic [DATA_W/8-1:0] out_keep,
	output logic out_last,
	output logic out_valid,
	input logic out_ready
);
	import deparser_pkg::*;

	localparam int BEAT_BYTES = DATA_W / 8;
	localparam int WIN_BYTES = HDR_BEATS * BEAT_BYTES;

	typedef enum logic [2:0] {
		S_IDLE, S_HDR1, S_TBL, S_START, S_PATCH, S_FLUSH0, S_FLUSH1, S_BODY
	} state_e;

	state_e state;
	logic [HDR_BEATS*DATA_W-1:0] win;
	logic [HDR_BEATS*DATA_W-1:0] patched;
	logic [WIN_BYTES-1:0] win_keep;
	logic [HDR_BEATS-1:0] win_last;
	logic [N_SLOTS-1:0][6:0] off_q;
	logic start_pkt;
	logic can_load;

	for (genvar s = 0; s < N_SLOTS; s++) begin : g_split
		assign acts[s] = row[s*ACT_W +: ACT_W];
	end

	assign start_pkt = (state == S_IDLE) && !pkt_empty && !phv_empty;
	// output register is free or drains this cycle
	assign can_load = !out_valid || out_ready;
	assign act_start = (state == S_START);
	assign phv_pop = (state == S_FLUSH0) && can_load;

	always_comb begin
		case (state)
			S_IDLE: pkt_pop = start_pkt;
			S_HDR1: pkt_pop = !pkt_empty;
			S_BODY: pkt_pop = can_load && !pkt_empty;
			default: pkt_pop = 1'b0;
		endcase
	end

	// slots in order, later ones win; msb to the lowest byte
	always_comb begin
		int unsigned pos;
		pos = 0;
		patched = win;
		for (int s = 0; s < N_SLOTS; s++) begin
			if (int'(off_q[s]) + int'(cont_len[s]) <= WIN_BYTES) begin
				for (int k = 0; k < 6; k++) begin
					if (k < int'(cont_len[s])) begin
						pos = off_q[s] + k;
						patched[8*pos +: 8] = cont_val[s][8*(cont_len[s]-1-k) +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= S_IDLE;
			win_last <= '0;
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end else begin
			if (out_ready) begin
				out_valid <= 1'b0;
			end
			case (state)
				S_IDLE: begin
					if (start_pkt) begin
						win_last[0] <= pkt_last;
						state <= pkt_last ? S_TBL : S_HDR1;
					end
				end
				S_HDR1: begin
					if (!pkt_empty) begin
						win_last[1] <= pkt_last;
						state <= S_TBL;
					end
				end
				S_TBL: state <= S_START;
				S_START: state <= S_PATCH;
				S_PATCH: state <= S_FLUSH0;
				S_FLUSH0: begin
					if (can_load) begin
						out_valid <= 1'b1;
						out_last <= win_last[0];
						state <= win_last[0] ? S_IDLE : S_FLUSH1;
					end
				end
				S_FLUSH1: begin
					if (can_load) begin
						out_valid <= 1'b1;
						out_last <= win_last[1];
						state <= win_last[1] ? S_IDLE : S_BODY;
					end
				end
				S_BODY: begin
					if (can_load && !pkt_empty) begin
						out_valid <= 1'b1;
						out_last <= pkt_last;
						if (pkt_last) begin
							state <= S_IDLE;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				if (start_pkt) begin
					win[0 +: DATA_W] <= pkt_data;
					win_keep[0 +: BEAT_BYTES] <= pkt_keep;
				end
			end
			S_HDR1: begin
				if (!pkt_empty) begin
					win[DATA_W +: DATA_W] <= pkt_data;
					win_keep[BEAT_BYTES +: BEAT_BYTES] <= pkt_keep;
				end
			end
			S_START: begin
				for (int s = 0; s < N_SLOTS; s++) begin
					off_q[s] <= acts[s].offset;
				end
			end
			S_PATCH: win <= patched;
			S_FLUSH0: begin
				if (can_load) begin
					out_data <= win[0 +: DATA_W];
					out_keep <= win_keep[0 +: BEAT_BYTES];
				end
			end
			S_FLUSH1: begin
				if (can_load) begin
					out_data <= win[DATA_W +: DATA_W];
					out_keep <= win_keep[BEAT_BYTES +: BEAT_BYTES];
				end
			end
			S_BODY: begin
				if (can_load && !pkt_empty) begin
					out_data <= pkt_data;
					out_keep <= pkt_keep;
				end
			end
			default: begin
			end
		endcase
	end

	// a stalled beat is held until the sink takes it
	out_stable: assert property (@(posedge clk) disable iff (!aresetn)
		out_valid && !out_ready |=> out_valid && $stable(out_data) &&
		$stable(out_keep) && $stable(out_last));

endmodule

/* deparser_top.sv */
`timescale 1ns/100ps

module deparser_top #(
	parameter int DATA_W = deparser_pkg::DATA_W,
	parameter int N_SLOTS = deparser_pkg::N_SLOTS,
	parameter int TBL_DEPTH = deparser_pkg::TBL_DEPTH
) (
	input logic clk,
	input logic aresetn,
	input logic [DATA_W-1:0] pkt_data,
	input logic [DATA_W/8-1:0] pkt_keep,
	input logic pkt_last,
	input logic pkt_empty,
	output logic pkt_pop,
	input deparser_pkg::phv_t phv,
	input logic phv_empty,
	output logic phv_pop,
	output logic [DATA_W-1:0] out_data,
	output logic [DATA_W/8-1:0] out_keep,
	output logic out_last,
	output logic out_valid,
	input logic out_ready,
	input logic [DATA_W-1:0] ctrl_data,
	input logic ctrl_valid,
	input logic ctrl_last
);
	import deparser_pkg::*;

	localparam int ROW_BITS = ACT_W * N_SLOTS;
	localparam int ADDR_W = $clog2(TBL_DEPTH);

	logic [ADDR_W-1:0] rd_addr;
	logic [ROW_BITS-1:0] row;
	action_t [N_SLOTS-1:0] acts;
	logic act_start;
	logic [N_SLOTS-1:0][47:0] cont_val;
	logic [N_SLOTS-1:0][2:0] cont_len;

	// row follows the phv at the fifo head
	assign rd_addr = phv.vlan_id[VLAN_IDX_LSB +: ADDR_W];

	action_table #(
		.DATA_W(DATA_W),
		.ROW_W(ROW_BITS),
		.TBL_DEPTH(TBL_DEPTH)
	) u_table (
		.clk(clk),
		.aresetn(aresetn),
		.ctrl_data(ctrl_data),
		.ctrl_valid(ctrl_valid),
		.ctrl_last(ctrl_last),
		.rd_addr(rd_addr),
		.row(row)
	);

	for (genvar g = 0; g < N_SLOTS; g++) begin : g_sub
		sub_deparser u_sub (
			.clk(clk),
			.aresetn(aresetn),
			.act(acts[g]),
			.act_start(act_start),
			.phv(phv),
			.cont_val(cont_val[g]),
			.cont_len(cont_len[g])
		);
	end

	deparse_ctrl #(
		.DATA_W(DATA_W),
		.N_SLOTS(N_SLOTS)
	) u_ctrl (
		.clk(clk),
		.aresetn(aresetn),
		.pkt_data(pkt_data),
		.pkt_keep(pkt_keep),
		.pkt_last(pkt_last),
		.pkt_empty(pkt_empty),
		.pkt_pop(pkt_pop),
		.phv_empty(phv_empty),
		.phv_pop(phv_pop),
		.row(row),
		.acts(acts),
		.act_start(act_start),
		.cont_val(cont_val),
		.cont_len(cont_len),
		.out_data(out_data),
		.out_keep(out_keep),
		.out_last(out_last),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

/* tb_deparser_cases.svh */
// columns: load kind, start row, row count, rows {row1, row0}, vlan id,
// phv base, packet base, beats, last keep, stall percent, chain with next
localparam int N_CASES = 8;

case_t cases [N_CASES];

task automatic fill_cases();
	// single beat, one 2-byte action at offset 2
	cases[0] = '{LD_GOOD, 1, 1,
		{64'd0, pack_row(encode_action(1, 2, CONT_2B, 2), 16'd0, 16'd0, 16'd0)},
		12'h010, 8'h11, 8'h30, 1, 16'h0fff, 0, 1'b0};
	// crossing byte 16, invalid slot, overlap, write past the window
	cases[1] = '{LD_GOOD, 2, 1,
		{64'd0, pack_row(encode_action(1, 1, CONT_6B, 13), encode_action(0, 0, CONT_6B, 20),
		encode_action(1, 3, CONT_4B, 15), encode_action(1, 0, CONT_2B, 31))},
		12'h123, 8'h21, 8'h50, 2, 16'hffff, 0, 1'b0};
	// wrong module id, row 1 stays
	cases[2] = '{LD_BAD_ID, 1, 1,
		{64'd0, pack_row(encode_action(1, 0, CONT_4B, 0), 16'd0, 16'd0, 16'd0)},
		12'h01a, 8'h31, 8'h70, 2, 16'hffff, 0, 1'b0};
	// wrong flag, row 2 stays
	cases[3] = '{LD_BAD_FLAG, 2, 1,
		{64'd0, pack_row(encode_action(1, 3, CONT_6B, 4), 16'd0, 16'd0, 16'd0)},
		12'h42a, 8'h41, 8'h90, 3, 16'h00ff, 0, 1'b0};
	// two rows at 5 and 6, packet uses row 6
	cases[4] = '{LD_GOOD, 5, 2,
		{pack_row(encode_action(1, 0, CONT_4B, 17), encode_action(1, 1, CONT_2B, 26),
		encode_action(1, 3, CONT_6B, 5), 16'd0),
		pack_row(encode_action(1, 3, CONT_2B, 0), encode_action(1, 2, CONT_6B, 8),
		16'd0, encode_action(1, 1, CONT_4B, 28))},
		12'h065, 8'h51, 8'hb0, 2, 16'hffff, 0, 1'b0};
	// long packet under stalls, then one more straight behind it
	cases[5] = '{LD_NONE, 0, 0, {64'd0, 64'd0},
		12'h050, 8'h61, 8'hd0, 5, 16'h003f, 50, 1'b1};
	cases[6] = '{LD_NONE, 0, 0, {64'd0, 64'd0},
		12'h02b, 8'h71, 8'h0f, 3, 16'hffff, 50, 1'b0};
	// load wraps from row 15 to row 0
	cases[7] = '{LD_GOOD, 15, 2,
		{pack_row(encode_action(1, 2, CONT_4B, 6), encode_action(1, 0, CONT_6B, 9), 16'd0,
		16'd0),
		pack_row(encode_action(1, 1, CONT_2B, 1), 16'd0, 16'd0, 16'd0)},
		12'h30f, 8'h81, 8'h2e, 1, 16'hffff, 20, 1'b0};
endtask

/* tb_deparser.sv */
`timescale 1ns/100ps

module tb_deparser;
	import deparser_pkg::*;

	localparam int LD_NONE = 0;
	localparam int LD_GOOD = 1;
	localparam int LD_BAD_ID = 2;
	localparam int LD_BAD_FLAG = 3;
	localparam int WIN_W = HDR_BYTES * 8;
	localparam int DRAIN_LIMIT = 2000;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [KEEP_W-1:0] keep;
		logic last;
	} beat_t;

	typedef struct packed {
		int ld_kind;
		int ld_start;
		int ld_rows;
		logic [1:0][ROW_W-1:0] rows;
		logic [11:0] vlan;
		logic [7:0] phv_base;
		logic [7:0] pkt_base;
		int nbeats;
		logic [KEEP_W-1:0] last_keep;
		int stall_pct;
		logic chain;
	} case_t;

	logic clk = 1'b0;
	logic aresetn;
	logic [DATA_W-1:0] pkt_data;
	logic [KEEP_W-1:0] pkt_keep;
	logic pkt_last;
	logic pkt_empty;
	logic pkt_pop;
	phv_t phv;
	logic phv_empty;
	logic phv_pop;
	logic [DATA_W-1:0] out_data;
	logic [KEEP_W-1:0] out_keep;
	logic out_last;
	logic out_valid;
	logic out_ready;
	logic [DATA_W-1:0] ctrl_data;
	logic ctrl_valid;
	logic ctrl_last;

	beat_t pkt_q [$];
	phv_t phv_q [$];
	beat_t exp_q [$];
	logic [ROW_W-1:0] shadow [TBL_DEPTH];
	int stall_pct = 0;
	logic pkt_take;
	logic phv_take;

	deparser_top uut (
		.clk(clk),
		.aresetn(aresetn),
		.pkt_data(pkt_data),
		.pkt_keep(pkt_keep),
		.pkt_last(pkt_last),
		.pkt_empty(pkt_empty),
		.pkt_pop(pkt_pop),
		.phv(phv),
		.phv_empty(phv_empty),
		.phv_pop(phv_pop),
		.out_data(out_data),
		.out_keep(out_keep),
		.out_last(out_last),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.ctrl_data(ctrl_data),
		.ctrl_valid(ctrl_valid),
		.ctrl_last(ctrl_last)
	);

	always #2 clk = ~clk;

	task automatic stop_run(string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_eq(string what, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("ERR %0t %s: got %0h, expected %0h", $time, what, got, exp));
		end
	endtask

	function automatic logic [ACT_W-1:0] encode_action(bit v, int idx, cont_kind_e kind, int off);
		action_t a;
		a = '0;
		a.valid = v;
		a.idx = 3'(idx);
		a.kind = kind;
		a.offset = 7'(off);
		return a;
	endfunction

	function automatic logic [ROW_W-1:0] pack_row(logic [ACT_W-1:0] a0, logic [ACT_W-1:0] a1,
		logic [ACT_W-1:0] a2, logic [ACT_W-1:0] a3);
		return {a3, a2, a1, a0};
	endfunction

	function automatic phv_t build_phv(logic [7:0] base, logic [11:0] vlan);
		phv_t p;
		p.vlan_id = vlan;
		for (int i = 0; i < N_CONT; i++) begin
			p.c2[i] = {8'(8'h20 + i), 8'(base + i)};
			p.c4[i] = {8'(8'h40 + i), 8'h4a, 8'(8'h4b + i), 8'(base + i)};
			p.c6[i] = {8'(8'h60 + i), 8'h6a, 8'h6b, 8'h6c, 8'(8'h6d + i), 8'(base + i)};
		end
		return p;
	endfunction

	function automatic logic [7:0] pkt_byte(logic [7:0] base, int pos);
		return 8'(base + pos * 7);
	endfunction

	// slot order, msb first, writes past the window dropped
	function automatic logic [WIN_W-1:0] ref_patch(logic [WIN_W-1:0] win,
		logic [ROW_W-1:0] row, phv_t p);
		action_t a;
		int len;
		logic [47:0] val;
		logic [WIN_W-1:0] w;
		w = win;
		for (int s = 0; s < N_SLOTS; s++) begin
			a = action_t'(row[s*ACT_W +: ACT_W]);
			len = 0;
			val = '0;
			if (a.valid) begin
				case (a.kind)
					CONT_2B: begin
						len = 2;
						val = 48'(p.c2[a.idx[1:0]]);
					end
					CONT_4B: begin
						len = 4;
						val = 48'(p.c4[a.idx[1:0]]);
					end
					CONT_6B: begin
						len = 6;
						val = p.c6[a.idx[1:0]];
					end
					default: len = 0;
				endcase
			end
			if (int'(a.offset) + len <= HDR_BYTES) begin
				for (int k = 0; k < len; k++) begin
					w[8*(int'(a.offset) + k) +: 8] = val[8*(len-1-k) +: 8];
				end
			end
		end
		return w;
	endfunction

	`include "tb_deparser_cases.svh"

	task automatic load_table(case_t c);
		logic [DATA_W-1:0] hdr;
		hdr = '0;
		hdr[CTRL_ID_LSB +: 3] = (c.ld_kind == LD_BAD_ID) ? 3'd4 : DEPARSER_ID;
		hdr[CTRL_FLAG_LSB +: 16] = (c.ld_kind == LD_BAD_FLAG) ? 16'hf2f0 : CTRL_FLAG;
		hdr[CTRL_IDX_LSB +: TBL_AW] = TBL_AW'(c.ld_start);
		@(posedge clk);
		#0.5;
		ctrl_data = hdr;
		ctrl_valid = 1'b1;
		ctrl_last = 1'b0;
		for (int k = 0; k < c.ld_rows; k++) begin
			@(posedge clk);
			#0.5;
			ctrl_data = DATA_W'(c.rows[k]);
			ctrl_last = (k == c.ld_rows - 1);
			if (c.ld_kind == LD_GOOD) begin
				shadow[(c.ld_start + k) % TBL_DEPTH] = c.rows[k];
			end
		end
		@(posedge clk);
		#0.5;
		ctrl_valid = 1'b0;
		ctrl_last = 1'b0;
		ctrl_data = '0;
	endtask

	task automatic push_case(case_t c);
		beat_t b;
		beat_t beats [$];
		logic [WIN_W-1:0] win;
		logic [WIN_W-1:0] patched;
		phv_t p;
		p = build_phv(c.phv_base, c.vlan);
		win = '0;
		for (int n = 0; n < c.nbeats; n++) begin
			for (int lane = 0; lane < KEEP_W; lane++) begin
				b.data[8*lane +: 8] = pkt_byte(c.pkt_base, n * KEEP_W + lane);
			end
			b.keep = (n == c.nbeats - 1) ? c.last_keep : '1;
			b.last = (n == c.nbeats - 1);
			if (n < HDR_BEATS) begin
				win[n*DATA_W +: DATA_W] = b.data;
			end
			pkt_q.push_back(b);
			beats.push_back(b);
		end
		phv_q.push_back(p);
		patched = ref_patch(win, shadow[c.vlan[VLAN_IDX_LSB +: TBL_AW]], p);
		for (int n = 0; n < c.nbeats; n++) begin
			b = beats[n];
			if (n < HDR_BEATS) begin
				b.data = patched[n*DATA_W +: DATA_W];
			end
			exp_q.push_back(b);
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (exp_q.size() > 0) begin
			@(posedge clk);
			cycles++;
			if (cycles > DRAIN_LIMIT) begin
				stop_run("timeout: expected output beats did not all arrive");
			end
		end
		check_eq("packet FIFO left over", pkt_q.size(), 0);
		check_eq("PHV FIFO left over", phv_q.size(), 0);
	endtask

	task automatic compare_beat();
		beat_t e;
		if (exp_q.size() == 0) begin
			stop_run("output beat arrived while none was expected");
		end else begin
			e = exp_q.pop_front();
			check_eq("out_data", out_data, e.data);
			check_eq("out_keep", out_keep, e.keep);
			check_eq("out_last", out_last, e.last);
		end
	endtask

	task automatic check_quiet();
		check_eq("out_valid at reset", out_valid, 0);
		check_eq("pkt_pop at reset", pkt_pop, 0);
		check_eq("phv_pop at reset", phv_pop, 0);
	endtask

	// FIFO models and output sink
	initial begin
		void'($urandom(2));
		pkt_data = '0;
		pkt_keep = '0;
		pkt_last = 1'b0;
		pkt_empty = 1'b1;
		phv = '0;
		phv_empty = 1'b1;
		out_ready = 1'b0;
		forever begin
			@(negedge clk);
			if (out_valid && out_ready) begin
				compare_beat();
			end
			if (pkt_pop && pkt_q.size() == 0) begin
				stop_run("packet FIFO popped while empty");
			end
			if (phv_pop && phv_q.size() == 0) begin
				stop_run("PHV FIFO popped while empty");
			end
			pkt_take = pkt_pop;
			phv_take = phv_pop;
			@(posedge clk);
			#0.5;
			if (pkt_take) begin
				void'(pkt_q.pop_front());
			end
			if (phv_take) begin
				void'(phv_q.pop_front());
			end
			pkt_empty = (pkt_q.size() == 0);
			if (pkt_q.size() > 0) begin
				pkt_data = pkt_q[0].data;
				pkt_keep = pkt_q[0].keep;
				pkt_last = pkt_q[0].last;
			end
			phv_empty = (phv_q.size() == 0);
			if (phv_q.size() > 0) begin
				phv = phv_q[0];
			end
			out_ready = (int'($urandom % 100) >= stall_pct);
		end
	end

	initial begin
		case_t cur;
		aresetn = 1'b0;
		ctrl_data = '0;
		ctrl_valid = 1'b0;
		ctrl_last = 1'b0;
		for (int i = 0; i < TBL_DEPTH; i++) begin
			shadow[i] = '0;
		end
		fill_cases();
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			check_quiet();
		end
		@(posedge clk);
		#0.5;
		aresetn = 1'b1;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			check_quiet();
		end
		for (int i = 0; i < N_CASES; i++) begin
			cur = cases[i];
			if (cur.ld_kind != LD_NONE) begin
				load_table(cur);
			end
			@(negedge clk);
			stall_pct = cur.stall_pct;
			push_case(cur);
			// chained cases go in back to back
			if (!cur.chain) begin
				wait_drained();
			end
		end
		$display("Regression passed");
		$finish;
	end

endmodule

/* deparser_top.f */
+incdir+.
deparser_pkg.sv
action_table.sv
sub_deparser.sv
deparse_ctrl.sv
deparser_top.sv
tb_deparser.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_deparser \
	-f deparser_top.f -o tb_deparser > sim.log 2>&1 &&
	./obj_dir/tb_deparser >> sim.log 2>&1
grep -q "^Regression passed$" sim.log && echo "run_sim: simulation ok" || {
	tail -n 20 sim.log
	exit 1
}
